// File: common/husky_config.svh
`ifndef HUSKY_CONFIG_SVH
`define HUSKY_CONFIG_SVH

// host register bus
`define HUSKY_ADDR_W 8
`define HUSKY_DATA_W 8

// shared capture fifo
`define HUSKY_FIFO_DEPTH 16
`define HUSKY_FIFO_PTR_W 4
`define HUSKY_FIFO_CNT_W 5  // holds 0 to depth

// error led flash, pattern flips once per divider period
`define HUSKY_FLASH_DIV 16
`define HUSKY_FLASH_CNT_W 4

// REG_CTRL bit positions
`define HUSKY_CTRL_SRC_BIT 0  // 1 = logic analyzer, 0 = trace
`define HUSKY_CTRL_CLR_BIT 1  // write 1 to clear errors

`endif

// File: common/husky_pkg.sv
`default_nettype none
`include "husky_config.svh"

package husky_pkg;

   // host register map
   // addresses not listed here read back as zero
   typedef enum logic [`HUSKY_ADDR_W-1:0] {
      REG_CTRL      = 8'h01,  // source select and clear errors
      REG_STATUS    = 8'h02,  // fifo count and flags
      REG_SCRATCH   = 8'h03,
      REG_FIFO_READ = 8'h04   // head of capture fifo, popped at end of read
   } reg_addr_e;

   // usb front end states
   typedef enum logic [1:0] {
      IDLE,
      READ,   // RDn held low, data driven out
      WRITE   // waiting for WRn to return high
   } bus_state_e;

endpackage

`default_nettype wire

// File: usb/usb_reg_bus.sv
`default_nettype none
`include "husky_config.svh"

module usb_reg_bus (
   input  wire                       clk_usb_buf,
   input  wire                       rst_i,
   input  wire [`HUSKY_ADDR_W-1:0]   usb_addr_i,
   input  wire [`HUSKY_DATA_W-1:0]   usb_din_i,
   input  wire                       usb_rdn_i,
   input  wire                       usb_wrn_i,
   input  wire                       usb_cen_i,
   input  wire                       usb_alen_i,
   input  wire [`HUSKY_DATA_W-1:0]   reg_rdata_i,
   output logic [`HUSKY_DATA_W-1:0]  usb_dout_o,
   output logic                      usb_isout_o,
   output husky_pkg::reg_addr_e      reg_address_o,
   output logic [`HUSKY_DATA_W-1:0]  reg_wdata_o,
   output logic                      reg_read_o,
   output logic                      reg_write_o,
   output logic                      fifo_pop_o
);

   logic                      rdn_q, rdn_qq;
   logic                      wrn_q, wrn_qq;
   logic                      cen_q;
   logic                      alen_q;
   logic [`HUSKY_ADDR_W-1:0]  addr_q;
   logic [`HUSKY_DATA_W-1:0]  din_q;
   logic                      rd_fall;
   logic                      wr_fall;
   logic                      wr_rise;
   husky_pkg::bus_state_e     state;

   // strobes come from the host asynchronously, sample once
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         rdn_q  <= 1'b1;  // all strobes idle high
         rdn_qq <= 1'b1;
         wrn_q  <= 1'b1;
         wrn_qq <= 1'b1;
         cen_q  <= 1'b1;
         alen_q <= 1'b1;
      end else begin
         rdn_q  <= usb_rdn_i;
         rdn_qq <= rdn_q;
         wrn_q  <= usb_wrn_i;
         wrn_qq <= wrn_q;
         cen_q  <= usb_cen_i;
         alen_q <= usb_alen_i;
      end
   end

   assign rd_fall = rdn_qq & ~rdn_q;
   assign wr_fall = wrn_qq & ~wrn_q;
   assign wr_rise = ~wrn_qq & wrn_q;

   always_ff @(posedge clk_usb_buf) begin
      addr_q <= usb_addr_i;
      din_q  <= usb_din_i;
      if (!alen_q)
         reg_address_o <= husky_pkg::reg_addr_e'(addr_q);
      if (!wrn_q)
         reg_wdata_o <= din_q;  // ends up with data from last low cycle
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         state       <= husky_pkg::IDLE;
         reg_read_o  <= 1'b0;
         reg_write_o <= 1'b0;
         fifo_pop_o  <= 1'b0;
         usb_isout_o <= 1'b0;
      end else begin
         reg_read_o  <= 1'b0;
         reg_write_o <= 1'b0;
         fifo_pop_o  <= 1'b0;
         case (state)
            husky_pkg::IDLE: begin
               if (rd_fall && !cen_q) begin
                  state       <= husky_pkg::READ;
                  reg_read_o  <= 1'b1;
                  usb_isout_o <= 1'b1;
               end else if (wr_fall && !cen_q) begin
                  state <= husky_pkg::WRITE;
               end
            end
            husky_pkg::READ: begin
               if (rdn_q) begin
                  state       <= husky_pkg::IDLE;
                  usb_isout_o <= 1'b0;
                  // host has taken the head word, advance
                  fifo_pop_o  <= (reg_address_o == husky_pkg::REG_FIFO_READ);
               end
            end
            husky_pkg::WRITE: begin
               if (wr_rise) begin
                  state       <= husky_pkg::IDLE;
                  reg_write_o <= 1'b1;
               end
            end
            default: state <= husky_pkg::IDLE;
         endcase
      end
   end

   // pad tristate lives outside, isout tells it to drive
   assign usb_dout_o = usb_isout_o ? reg_rdata_i : '0;

endmodule

`default_nettype wire

// File: src/reg_control.sv
`default_nettype none
`include "husky_config.svh"

module reg_control (
   input  wire                          clk_usb_buf,
   input  wire                          rst_i,
   input  wire husky_pkg::reg_addr_e    reg_address_i,
   input  wire [`HUSKY_DATA_W-1:0]      reg_wdata_i,
   input  wire                          reg_write_i,
   input  wire                          reg_read_i,
   input  wire [`HUSKY_FIFO_CNT_W-1:0]  fifo_count_i,
   input  wire                          fifo_empty_i,
   input  wire                          fifo_full_i,
   input  wire                          fifo_overflow_i,
   output logic [`HUSKY_DATA_W-1:0]     reg_rdata_o,
   output logic                         src_sel_o,
   output logic                         clear_errors_o
);

   logic [`HUSKY_DATA_W-1:0]  scratch;
   logic [`HUSKY_DATA_W-1:0]  status_q;
   logic [`HUSKY_DATA_W-1:0]  ctrl_rd;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         src_sel_o      <= 1'b0;  // trace by default
         clear_errors_o <= 1'b0;
         scratch        <= '0;
      end else begin
         clear_errors_o <= 1'b0;
         if (reg_write_i) begin
            case (reg_address_i)
               husky_pkg::REG_CTRL: begin
                  src_sel_o      <= reg_wdata_i[`HUSKY_CTRL_SRC_BIT];
                  clear_errors_o <= reg_wdata_i[`HUSKY_CTRL_CLR_BIT];  // one cycle only
               end
               husky_pkg::REG_SCRATCH: scratch <= reg_wdata_i;
               default: ;
            endcase
         end
      end
   end

   // status frozen at start of each read so the host sees one consistent byte
   always_ff @(posedge clk_usb_buf) begin
      if (reg_read_i)
         status_q <= {fifo_overflow_i, fifo_full_i, fifo_empty_i, fifo_count_i};
   end

   always_comb begin
      ctrl_rd = '0;
      ctrl_rd[`HUSKY_CTRL_SRC_BIT] = src_sel_o;  // clear bit always reads 0
   end

   always_comb begin
      case (reg_address_i)
         husky_pkg::REG_CTRL:    reg_rdata_o = ctrl_rd;
         husky_pkg::REG_STATUS:  reg_rdata_o = status_q;
         husky_pkg::REG_SCRATCH: reg_rdata_o = scratch;
         default:                reg_rdata_o = '0;  // other blocks own these
      endcase
   end

endmodule

`default_nettype wire

// File: capture/capture_fifo.sv
`default_nettype none
`include "husky_config.svh"

module capture_fifo (
   input  wire                           clk_usb_buf,
   input  wire                           rst_i,
   input  wire                           trace_wr_i,
   input  wire [`HUSKY_DATA_W-1:0]       trace_data_i,
   input  wire                           la_wr_i,
   input  wire [`HUSKY_DATA_W-1:0]       la_data_i,
   input  wire                           src_sel_i,
   input  wire                           fifo_pop_i,
   input  wire                           clear_errors_i,
   output logic [`HUSKY_DATA_W-1:0]      fifo_rdata_o,
   output logic [`HUSKY_FIFO_CNT_W-1:0]  fifo_count_o,
   output logic                          fifo_empty_o,
   output logic                          fifo_full_o,
   output logic                          fifo_overflow_o
);

   logic [`HUSKY_DATA_W-1:0]     mem [`HUSKY_FIFO_DEPTH];
   logic [`HUSKY_FIFO_PTR_W-1:0] wr_ptr;
   logic [`HUSKY_FIFO_PTR_W-1:0] rd_ptr;
   logic                         src_wr;
   logic [`HUSKY_DATA_W-1:0]     src_data;
   logic                         do_wr;
   logic                         do_rd;

   // one source at a time feeds the shared buffer
   assign src_wr   = src_sel_i ? la_wr_i : trace_wr_i;
   assign src_data = src_sel_i ? la_data_i : trace_data_i;

   assign fifo_empty_o = (fifo_count_o == '0);
   assign fifo_full_o  = (fifo_count_o == `HUSKY_FIFO_DEPTH);

   // no back pressure, a write into a full fifo is simply lost
   assign do_wr = src_wr & ~fifo_full_o;
   assign do_rd = fifo_pop_i & ~fifo_empty_o;

   always_ff @(posedge clk_usb_buf) begin
      if (do_wr)
         mem[wr_ptr] <= src_data;
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         fifo_count_o <= '0;
      end else begin
         case ({do_wr, do_rd})
            2'b10:   fifo_count_o <= fifo_count_o + 1'b1;
            2'b01:   fifo_count_o <= fifo_count_o - 1'b1;
            default: ;  // push and pop together leave count alone
         endcase
      end
   end

   // sticky until host clears it
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         fifo_overflow_o <= 1'b0;
      end else if (clear_errors_i) begin
         fifo_overflow_o <= 1'b0;
      end else if (src_wr && fifo_full_o) begin
         fifo_overflow_o <= 1'b1;
      end
   end

   // head word, empty reads as zero
   assign fifo_rdata_o = fifo_empty_o ? '0 : mem[rd_ptr];

endmodule

`default_nettype wire

// File: src/led_status.sv
`default_nettype none
`include "husky_config.svh"

module led_status (
   input  wire   clk_usb_buf,
   input  wire   rst_i,
   input  wire   error_i,
   input  wire   pll_status_i,
   output logic  led_adc_o
);

   logic [`HUSKY_FLASH_CNT_W-1:0] flash_cnt;
   logic                          flash_pattern;

   // free running, pattern flips once per full count
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         flash_cnt     <= '0;
         flash_pattern <= 1'b0;
      end else begin
         flash_cnt <= flash_cnt + 1'b1;
         if (flash_cnt == `HUSKY_FLASH_DIV - 1)
            flash_pattern <= ~flash_pattern;
      end
   end

   // fast flash on error, otherwise lit while pll is unlocked
   assign led_adc_o = error_i ? flash_pattern : ~pll_status_i;

endmodule

`default_nettype wire

// File: src/husky_top.sv
`default_nettype none
`include "husky_config.svh"

module husky_top (
   input  wire                       clk_usb_buf,
   input  wire                       rst_i,
   input  wire [`HUSKY_ADDR_W-1:0]   usb_addr_i,
   input  wire [`HUSKY_DATA_W-1:0]   usb_din_i,
   input  wire                       usb_rdn_i,
   input  wire                       usb_wrn_i,
   input  wire                       usb_cen_i,
   input  wire                       usb_alen_i,
   output logic [`HUSKY_DATA_W-1:0]  usb_dout_o,
   output logic                      usb_isout_o,
   input  wire                       trace_wr_i,
   input  wire [`HUSKY_DATA_W-1:0]   trace_data_i,
   input  wire                       la_wr_i,
   input  wire [`HUSKY_DATA_W-1:0]   la_data_i,
   input  wire                       pll_status_i,
   output logic                      led_adc_o
);

   husky_pkg::reg_addr_e          reg_address;
   logic [`HUSKY_DATA_W-1:0]      reg_wdata;
   logic                          reg_read;
   logic                          reg_write;
   logic                          fifo_pop;
   logic [`HUSKY_DATA_W-1:0]      ctrl_rdata;
   logic [`HUSKY_DATA_W-1:0]      fifo_rdata;
   logic [`HUSKY_DATA_W-1:0]      fifo_blk_rdata;
   logic [`HUSKY_DATA_W-1:0]      rdata_q;
   logic [`HUSKY_DATA_W-1:0]      usb_rdata;
   logic                          src_sel;
   logic                          clear_errors;
   logic [`HUSKY_FIFO_CNT_W-1:0]  fifo_count;
   logic                          fifo_empty;
   logic                          fifo_full;
   logic                          fifo_overflow;
   logic                          fifo_addr;

   assign fifo_addr      = (reg_address == husky_pkg::REG_FIFO_READ);
   assign fifo_blk_rdata = fifo_addr ? fifo_rdata : '0;

   // readback bus, each block drives zero outside its own addresses
   always_ff @(posedge clk_usb_buf) begin
      rdata_q <= ctrl_rdata | fifo_blk_rdata;
   end

   // registered path lags the head by a cycle after a pop, so fifo reads go direct
   assign usb_rdata = fifo_addr ? fifo_rdata : rdata_q;

   usb_reg_bus i_usb_reg_bus (
      .clk_usb_buf    (clk_usb_buf),
      .rst_i          (rst_i),
      .usb_addr_i     (usb_addr_i),
      .usb_din_i      (usb_din_i),
      .usb_rdn_i      (usb_rdn_i),
      .usb_wrn_i      (usb_wrn_i),
      .usb_cen_i      (usb_cen_i),
      .usb_alen_i     (usb_alen_i),
      .reg_rdata_i    (usb_rdata),
      .usb_dout_o     (usb_dout_o),
      .usb_isout_o    (usb_isout_o),
      .reg_address_o  (reg_address),
      .reg_wdata_o    (reg_wdata),
      .reg_read_o     (reg_read),
      .reg_write_o    (reg_write),
      .fifo_pop_o     (fifo_pop)
   );

   reg_control i_reg_control (
      .clk_usb_buf      (clk_usb_buf),
      .rst_i            (rst_i),
      .reg_address_i    (reg_address),
      .reg_wdata_i      (reg_wdata),
      .reg_write_i      (reg_write),
      .reg_read_i       (reg_read),
      .fifo_count_i     (fifo_count),
      .fifo_empty_i     (fifo_empty),
      .fifo_full_i      (fifo_full),
      .fifo_overflow_i  (fifo_overflow),
      .reg_rdata_o      (ctrl_rdata),
      .src_sel_o        (src_sel),
      .clear_errors_o   (clear_errors)
   );

   capture_fifo i_capture_fifo (
      .clk_usb_buf      (clk_usb_buf),
      .rst_i            (rst_i),
      .trace_wr_i       (trace_wr_i),
      .trace_data_i     (trace_data_i),
      .la_wr_i          (la_wr_i),
      .la_data_i        (la_data_i),
      .src_sel_i        (src_sel),
      .fifo_pop_i       (fifo_pop),
      .clear_errors_i   (clear_errors),
      .fifo_rdata_o     (fifo_rdata),
      .fifo_count_o     (fifo_count),
      .fifo_empty_o     (fifo_empty),
      .fifo_full_o      (fifo_full),
      .fifo_overflow_o  (fifo_overflow)
   );

   led_status i_led_status (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .error_i       (fifo_overflow),  // only error source kept
      .pll_status_i  (pll_status_i),
      .led_adc_o     (led_adc_o)
   );

endmodule

`default_nettype wire

// File: tests/husky_assert.sv
`default_nettype none
`include "husky_config.svh"

module husky_assert (
   input wire                          clk_usb_buf,
   input wire                          rst_i,
   input wire                          reg_read_i,
   input wire                          reg_write_i,
   input wire                          fifo_pop_i,
   input wire [`HUSKY_FIFO_CNT_W-1:0]  count_i
);

   read_write_apart: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      !(reg_read_i && reg_write_i))
      else $error("reg_read and reg_write high in the same cycle");

   read_one_cycle: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      reg_read_i |=> !reg_read_i)
      else $error("reg_read longer than one cycle");

   write_one_cycle: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      reg_write_i |=> !reg_write_i)
      else $error("reg_write longer than one cycle");

   pop_one_cycle: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      fifo_pop_i |=> !fifo_pop_i)
      else $error("fifo_pop longer than one cycle");

   count_in_range: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      count_i <= `HUSKY_FIFO_DEPTH)
      else $error("fifo count above depth");

endmodule

bind usb_reg_bus husky_assert i_bus_assert (
   .clk_usb_buf  (clk_usb_buf),
   .rst_i        (rst_i),
   .reg_read_i   (reg_read_o),
   .reg_write_i  (reg_write_o),
   .fifo_pop_i   (fifo_pop_o),
   .count_i      ('0)
);

bind capture_fifo husky_assert i_fifo_assert (
   .clk_usb_buf  (clk_usb_buf),
   .rst_i        (rst_i),
   .reg_read_i   (1'b0),
   .reg_write_i  (1'b0),
   .fifo_pop_i   (fifo_pop_i),
   .count_i      (fifo_count_o)
);

`default_nettype wire

// File: tests/husky_tb.sv
`default_nettype none
`include "husky_config.svh"

module husky_tb;

   localparam int OP_WRITE = 0;
   localparam int OP_READ  = 1;
   localparam int OP_TRACE = 2;
   localparam int OP_LA    = 3;
   localparam int OP_FLASH = 4;  // led must toggle while overflow is set
   localparam int OP_PLL   = 5;  // led follows inverted pll status

   logic                      clk_usb_buf = 1'b0;
   logic                      rst_i;
   logic [`HUSKY_ADDR_W-1:0]  usb_addr_i;
   logic [`HUSKY_DATA_W-1:0]  usb_din_i;
   logic                      usb_rdn_i;
   logic                      usb_wrn_i;
   logic                      usb_cen_i;
   logic                      usb_alen_i;
   logic [`HUSKY_DATA_W-1:0]  usb_dout_o;
   logic                      usb_isout_o;
   logic                      trace_wr_i;
   logic                      la_wr_i;
   logic [`HUSKY_DATA_W-1:0]  trace_data_i;
   logic [`HUSKY_DATA_W-1:0]  la_data_i;
   logic                      pll_status_i;
   logic                      led_adc_o;

   // stimulus table with one entry per row
   int                        op_q[$];
   int                        test_q[$];
   logic [`HUSKY_ADDR_W-1:0]  addr_q[$];
   logic [`HUSKY_DATA_W-1:0]  data_q[$];
   logic [`HUSKY_DATA_W-1:0]  exp_q[$];

   // reference state while the table is built
   logic [`HUSKY_DATA_W-1:0]  model_q[$];
   logic                      model_src;
   logic                      model_ovf;
   logic [`HUSKY_DATA_W-1:0]  model_scratch;

   int    seed = 32'h8ef3c7b7;
   int    checks = 0;
   int    errors = 0;
   int    test_errors = 0;
   int    cycles = 0;
   int    timeout_limit = 0;
   string test_names [1:6] = '{"scratch", "trace source", "la source", "overflow", "led",
                               "empty fifo"};

   husky_top i_dut (.*);

   always #4 clk_usb_buf = ~clk_usb_buf;

   always @(posedge clk_usb_buf) begin
      cycles <= cycles + 1;
      if (timeout_limit != 0 && cycles >= timeout_limit) begin
         $display("timeout: no end of test after %0d cycles", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic add_row(input int test, input int op, input logic [7:0] addr,
                          input logic [7:0] data);
      logic [7:0] exp;
      logic [4:0] cnt;
      exp = '0;
      cnt = 5'(model_q.size());
      case (op)
         OP_WRITE: begin
            if (addr == husky_pkg::REG_CTRL) begin
               model_src = data[`HUSKY_CTRL_SRC_BIT];
               if (data[`HUSKY_CTRL_CLR_BIT])
                  model_ovf = 1'b0;
            end else if (addr == husky_pkg::REG_SCRATCH) begin
               model_scratch = data;
            end
         end
         OP_READ: begin
            if (addr == husky_pkg::REG_CTRL)
               exp = {7'd0, model_src};
            else if (addr == husky_pkg::REG_SCRATCH)
               exp = model_scratch;
            else if (addr == husky_pkg::REG_STATUS)
               exp = {model_ovf, model_q.size() == `HUSKY_FIFO_DEPTH, cnt == 5'd0, cnt};
            else if (addr == husky_pkg::REG_FIFO_READ && model_q.size() > 0)
               exp = model_q.pop_front();  // empty fifo reads 0
         end
         OP_TRACE, OP_LA: begin
            // only the selected source is stored
            if ((op == OP_LA) == model_src) begin
               if (model_q.size() < `HUSKY_FIFO_DEPTH)
                  model_q.push_back(data);
               else
                  model_ovf = 1'b1;
            end
         end
         OP_FLASH: exp = 8'h01;
         OP_PLL:   exp = {7'd0, ~data[0]};
         default: ;
      endcase
      test_q.push_back(test);
      op_q.push_back(op);
      addr_q.push_back(addr);
      data_q.push_back(data);
      exp_q.push_back(exp);
   endtask

   task automatic build_table;
      int k;
      model_src = 1'b0;
      model_ovf = 1'b0;
      model_scratch = '0;
      add_row(1, OP_WRITE, husky_pkg::REG_SCRATCH, 8'h5a);
      add_row(1, OP_READ, husky_pkg::REG_SCRATCH, 8'h00);
      add_row(1, OP_WRITE, husky_pkg::REG_SCRATCH, 8'ha3);
      add_row(1, OP_READ, husky_pkg::REG_SCRATCH, 8'h00);
      add_row(1, OP_READ, 8'h7e, 8'h00);  // unused address
      for (k = 0; k < 5; k++) begin
         add_row(2, OP_TRACE, 8'h00, 8'($random(seed)));
         if (k % 2 == 0)
            add_row(2, OP_LA, 8'h00, 8'($random(seed)));  // not selected yet
      end
      add_row(2, OP_READ, husky_pkg::REG_STATUS, 8'h00);
      for (k = 0; k < 5; k++) begin
         add_row(2, OP_READ, husky_pkg::REG_FIFO_READ, 8'h00);
         add_row(2, OP_READ, husky_pkg::REG_STATUS, 8'h00);
      end
      add_row(3, OP_WRITE, husky_pkg::REG_CTRL, 8'h01);
      add_row(3, OP_READ, husky_pkg::REG_CTRL, 8'h00);
      for (k = 0; k < 3; k++) begin
         add_row(3, OP_LA, 8'h00, 8'($random(seed)));
         if (k < 2)
            add_row(3, OP_TRACE, 8'h00, 8'($random(seed)));
      end
      add_row(3, OP_READ, husky_pkg::REG_STATUS, 8'h00);
      for (k = 0; k < 3; k++)
         add_row(3, OP_READ, husky_pkg::REG_FIFO_READ, 8'h00);
      add_row(3, OP_WRITE, husky_pkg::REG_CTRL, 8'h00);
      for (k = 0; k <= `HUSKY_FIFO_DEPTH; k++)
         add_row(4, OP_TRACE, 8'h00, 8'($random(seed)));
      add_row(4, OP_READ, husky_pkg::REG_STATUS, 8'h00);
      for (k = 0; k <= `HUSKY_FIFO_DEPTH; k++)
         add_row(4, OP_READ, husky_pkg::REG_FIFO_READ, 8'h00);
      add_row(4, OP_READ, husky_pkg::REG_STATUS, 8'h00);
      add_row(5, OP_FLASH, 8'h00, 8'h00);
      add_row(5, OP_WRITE, husky_pkg::REG_CTRL, 8'h02);  // clear errors
      add_row(5, OP_READ, husky_pkg::REG_STATUS, 8'h00);
      add_row(5, OP_PLL, 8'h00, 8'h01);
      add_row(5, OP_PLL, 8'h00, 8'h00);
      add_row(6, OP_READ, husky_pkg::REG_FIFO_READ, 8'h00);
      add_row(6, OP_READ, husky_pkg::REG_STATUS, 8'h00);
   endtask

   task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         test_errors++;
         $display("FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   // ALEn held low two cycles so the address is taken
   task automatic set_address(input logic [7:0] addr);
      @(negedge clk_usb_buf);
      usb_addr_i = addr;
      usb_alen_i = 1'b0;
      repeat (2) @(negedge clk_usb_buf);
      usb_alen_i = 1'b1;
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      set_address(addr);
      usb_din_i = data;
      usb_cen_i = 1'b0;
      usb_wrn_i = 1'b0;
      repeat (3) @(negedge clk_usb_buf);
      usb_wrn_i = 1'b1;  // write pulse follows the rising edge
      repeat (3) @(negedge clk_usb_buf);
      usb_cen_i = 1'b1;
      repeat (2) @(negedge clk_usb_buf);
   endtask

   task automatic bus_read(input logic [7:0] addr, output logic [7:0] data, output logic isout);
      set_address(addr);
      usb_cen_i = 1'b0;
      usb_rdn_i = 1'b0;
      repeat (6) @(negedge clk_usb_buf);
      data = usb_dout_o;
      isout = usb_isout_o;
      usb_rdn_i = 1'b1;
      usb_cen_i = 1'b1;
      repeat (4) @(negedge clk_usb_buf);  // room for the fifo pop
   endtask

   task automatic push_word(input int op, input logic [7:0] data);
      @(negedge clk_usb_buf);
      if (op == OP_LA) begin
         la_wr_i = 1'b1;
         la_data_i = data;
      end else begin
         trace_wr_i = 1'b1;
         trace_data_i = data;
      end
      @(negedge clk_usb_buf);
      la_wr_i = 1'b0;
      trace_wr_i = 1'b0;
   endtask

   task automatic run_row(input int i);
      logic [7:0] rd;
      logic       isout;
      logic       led0;
      logic       toggled;
      case (op_q[i])
         OP_WRITE: bus_write(addr_q[i], data_q[i]);
         OP_READ: begin
            bus_read(addr_q[i], rd, isout);
            check_value({7'd0, isout}, 8'h01, "usb_isout_o during read");
            check_value(rd, exp_q[i], $sformatf("read of address %h", addr_q[i]));
            check_value({7'd0, usb_isout_o}, 8'h00, "usb_isout_o after read");
         end
         OP_TRACE, OP_LA: push_word(op_q[i], data_q[i]);
         OP_FLASH: begin
            led0 = led_adc_o;
            toggled = 1'b0;
            repeat (2 * `HUSKY_FLASH_DIV) begin
               @(negedge clk_usb_buf);
               if (led_adc_o !== led0)
                  toggled = 1'b1;
            end
            check_value({7'd0, toggled}, exp_q[i], "led flash while overflow set");
         end
         OP_PLL: begin
            @(negedge clk_usb_buf);
            pll_status_i = data_q[i][0];
            repeat (2) @(negedge clk_usb_buf);
            check_value({7'd0, led_adc_o}, exp_q[i], "led against pll status");
         end
         default: ;
      endcase
   endtask

   initial begin
      rst_i = 1'b1;
      usb_addr_i = '0;
      usb_din_i = '0;
      usb_rdn_i = 1'b1;
      usb_wrn_i = 1'b1;
      usb_cen_i = 1'b1;
      usb_alen_i = 1'b1;
      trace_wr_i = 1'b0;
      trace_data_i = '0;
      la_wr_i = 1'b0;
      la_data_i = '0;
      pll_status_i = 1'b1;
      build_table();
      timeout_limit = 4 * op_q.size() * 20;
      repeat (10) @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);
      rst_i = 1'b0;
      for (int i = 0; i < op_q.size(); i++) begin
         run_row(i);
         if (i == op_q.size() - 1 || test_q[i + 1] != test_q[i]) begin
            $display("test %0d %s finished, %0d errors", test_q[i], test_names[test_q[i]],
                     test_errors);
            test_errors = 0;
         end
      end
      $display("%0d rows, %0d checks, %0d errors", op_q.size(), checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/husky_pkg.sv
usb/usb_reg_bus.sv
src/reg_control.sv
capture/capture_fifo.sv
src/led_status.sv
src/husky_top.sv
tests/husky_assert.sv
tests/husky_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the husky testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module husky_tb -o husky_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/husky_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
